// ==== bench/vseq_testdata.txt ====
// op vd use_vd vs1 use_vs1 vs2 use_vs2 stall late_dly late_ids done_ids exp_id exp_unit exp_haz
// One request per line, hex; id fields are masks with one bit per instruction ID
02 01 01 00 00 00 00 00 00 00 00 00 01 00
00 02 01 01 01 03 01 00 00 00 00 01 00 01
02 03 01 00 00 00 00 00 00 00 02 02 01 02
00 04 01 02 01 03 01 03 00 00 00 01 00 04
02 05 01 00 00 00 00 00 04 01 00 00 01 00
04 04 01 00 00 00 00 00 03 02 07 01 00 00
03 00 00 05 01 00 00 00 00 00 01 00 02 00
01 06 01 07 01 08 01 00 00 00 00 00 00 00
00 06 01 09 01 00 00 00 00 00 03 01 00 01

// ==== files.f ====
source/vseq_pkg.sv
source/vid_tracker.sv
source/vreg_scoreboard.sv
source/unit_occupancy.sv
source/issue_ctrl.sv
source/vseq_top.sv
bench/vseq_sva.sv
bench/vseq_checker.sv
bench/tb_vseq.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_vseq -Mdir obj_dir
	./obj_dir/Vtb_vseq > sim.log 2>&1
	cat sim.log
	! grep -q "=== FAIL ===" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/tb_vseq.sv ====
/* Vector sequencer testbench */

`timescale 1ns/100ps
`default_nettype none

module tb_vseq;

  localparam int NumFields     = 14;
  localparam int MaxTests      = 32;
  localparam int CyclesPerTest = 200;
  localparam int ResetCycles   = 10;

  // Wide entries so slots the file leaves untouched keep the top bit
  logic [15:0] test_mem [NumFields*MaxTests];
  logic [1:0]  id_unit [vseq_pkg::NrVInsn];

  logic                                        clk_i;
  logic                                        rst_ni;
  logic                                        req_valid;
  vseq_pkg::vinsn_op_e                         req_op;
  vseq_pkg::vreg_t                             req_vd, req_vs1, req_vs2;
  logic                                        req_use_vd, req_use_vs1, req_use_vs2;
  logic                                        req_ready;
  logic [vseq_pkg::NrUnits-1:0]                unit_ready;
  vseq_pkg::vid_mask_t [vseq_pkg::NrUnits-1:0] unit_done;
  logic                                        issue_valid;
  vseq_pkg::vid_t                              issue_id;
  vseq_pkg::vinsn_op_e                         issue_op;
  vseq_pkg::unit_e                             issue_unit;
  vseq_pkg::vreg_t                             issue_vd, issue_vs1, issue_vs2;
  vseq_pkg::vid_mask_t                         issue_hazard;
  logic                                        idle;

  // Expected values to the checker
  logic       exp_valid;
  logic [1:0] exp_id, exp_unit;
  logic [3:0] exp_hazard;
  logic       end_check;
  int         err_cnt, test_cnt, pending;

  int num_tests;
  int cycle_cnt;
  int cycle_limit;

  vseq_top i_dut (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_valid_i    (req_valid),
    .req_op_i       (req_op),
    .req_vd_i       (req_vd),
    .req_use_vd_i   (req_use_vd),
    .req_vs1_i      (req_vs1),
    .req_use_vs1_i  (req_use_vs1),
    .req_vs2_i      (req_vs2),
    .req_use_vs2_i  (req_use_vs2),
    .req_ready_o    (req_ready),
    .unit_ready_i   (unit_ready),
    .unit_done_i    (unit_done),
    .issue_valid_o  (issue_valid),
    .issue_id_o     (issue_id),
    .issue_op_o     (issue_op),
    .issue_unit_o   (issue_unit),
    .issue_vd_o     (issue_vd),
    .issue_vs1_o    (issue_vs1),
    .issue_vs2_o    (issue_vs2),
    .issue_hazard_o (issue_hazard),
    .idle_o         (idle)
  );

  // Register fields are expected back exactly as requested
  vseq_checker i_checker (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .exp_valid_i    (exp_valid),
    .exp_id_i       (exp_id),
    .exp_unit_i     (exp_unit),
    .exp_hazard_i   (exp_hazard),
    .exp_op_i       (req_op),
    .exp_vd_i       (req_vd),
    .exp_vs1_i      (req_vs1),
    .exp_vs2_i      (req_vs2),
    .end_check_i    (end_check),
    .req_ready_i    (req_ready),
    .unit_ready_i   (unit_ready),
    .issue_valid_i  (issue_valid),
    .issue_id_i     (issue_id),
    .issue_op_i     (issue_op),
    .issue_unit_i   (issue_unit),
    .issue_vd_i     (issue_vd),
    .issue_vs1_i    (issue_vs1),
    .issue_vs2_i    (issue_vs2),
    .issue_hazard_i (issue_hazard),
    .idle_i         (idle),
    .err_cnt_o      (err_cnt),
    .test_cnt_o     (test_cnt),
    .pending_o      (pending)
  );

  ////////////////////////////////////////
  // Clock and timeout
  ////////////////////////////////////////

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
      $display("Timeout after %0d cycles, the DUT stopped making progress", cycle_cnt);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // One completion pulse per ID, routed to the unit that took it
  task automatic complete_ids(input logic [3:0] mask);
    for (int i = 0; i < vseq_pkg::NrVInsn; i++) begin
      if (mask[i]) begin
        unit_done[id_unit[i]][i] = 1'b1;
        @(posedge clk_i);
        #2;
        unit_done = '0;
      end
    end
  endtask

  // Acceptance decided by req_ready at mid cycle
  task automatic wait_accept();
    logic accepted;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk_i);
      accepted = req_ready;
      @(posedge clk_i);
      #2;
      exp_valid = 1'b0;
    end
    req_valid = 1'b0;
  endtask

  task automatic run_test(input int t);
    logic [7:0] f [NumFields];
    logic       taken;
    for (int k = 0; k < NumFields; k++) begin
      f[k] = test_mem[t*NumFields + k][7:0];
    end
    req_op      = vseq_pkg::vinsn_op_e'(f[0][2:0]);
    req_vd      = f[1][4:0];
    req_use_vd  = f[2][0];
    req_vs1     = f[3][4:0];
    req_use_vs1 = f[4][0];
    req_vs2     = f[5][4:0];
    req_use_vs2 = f[6][0];
    req_valid   = 1'b1;
    exp_id      = f[11][1:0];
    exp_unit    = f[12][1:0];
    exp_hazard  = f[13][3:0];
    exp_valid   = 1'b1;
    // Completions that free the request while it waits
    fork
      begin
        if (f[9] != 8'h00) begin
          repeat (f[8]) @(posedge clk_i);
          #2;
          complete_ids(f[9][3:0]);
        end
      end
      wait_accept();
    join
    // The new ID now belongs to its unit
    id_unit[f[11][1:0]] = f[12][1:0];
    // Back-pressure from the target unit
    if (f[7] != 8'h00) begin
      unit_ready[f[12][1:0]] = 1'b0;
      repeat (f[7]) begin
        @(posedge clk_i);
        #2;
      end
      unit_ready[f[12][1:0]] = 1'b1;
    end
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk_i);
      taken = issue_valid && unit_ready[issue_unit];
      @(posedge clk_i);
      #2;
    end
    complete_ids(f[10][3:0]);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    req_valid   = 1'b0;
    req_op      = vseq_pkg::OP_VADD;
    req_vd      = '0;
    req_vs1     = '0;
    req_vs2     = '0;
    req_use_vd  = 1'b0;
    req_use_vs1 = 1'b0;
    req_use_vs2 = 1'b0;
    unit_ready  = '1;
    unit_done   = '0;
    exp_valid   = 1'b0;
    exp_id      = '0;
    exp_unit    = '0;
    exp_hazard  = '0;
    end_check   = 1'b0;
    cycle_cnt   = 0;
    cycle_limit = 0;
    num_tests   = 0;
    for (int i = 0; i < vseq_pkg::NrVInsn; i++) id_unit[i] = '0;

    // Address in the low bits, top bit marks a slot with no file data
    for (int i = 0; i < NumFields*MaxTests; i++) begin
      test_mem[i] = 16'h8000 | 16'(i);
    end
    $readmemh("bench/vseq_testdata.txt", test_mem);
    while (num_tests < MaxTests && !test_mem[num_tests*NumFields][15]) begin
      num_tests++;
    end
    cycle_limit = CyclesPerTest * num_tests + ResetCycles;
    if (num_tests == 0) $display("No test vectors found in the data file");

    repeat (ResetCycles) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    for (int t = 0; t < num_tests; t++) begin
      run_test(t);
    end

    // Everything completed, idle must be back
    repeat (2) @(posedge clk_i);
    #2;
    end_check = 1'b1;
    @(posedge clk_i);
    #2;
    end_check = 1'b0;
    @(posedge clk_i);

    $display("Tests: %0d of %0d checked, errors: %0d", test_cnt, num_tests, err_cnt);
    if (pending != 0 || test_cnt != num_tests) begin
      $display("Issue count differs from the number of requests");
    end
    if (err_cnt == 0 && pending == 0 && num_tests > 0 && test_cnt == num_tests) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/vseq_checker.sv ====
/* Issue port checker */

`timescale 1ns/100ps
`default_nettype none

module vseq_checker (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // Expected issue, one strobe per request
  input  logic                         exp_valid_i,
  input  logic [1:0]                   exp_id_i,
  input  logic [1:0]                   exp_unit_i,
  input  logic [3:0]                   exp_hazard_i,
  input  vseq_pkg::vinsn_op_e          exp_op_i,
  input  vseq_pkg::vreg_t              exp_vd_i,
  input  vseq_pkg::vreg_t              exp_vs1_i,
  input  vseq_pkg::vreg_t              exp_vs2_i,
  input  logic                         end_check_i,
  // Observed DUT signals
  input  logic                         req_ready_i,
  input  logic [vseq_pkg::NrUnits-1:0] unit_ready_i,
  input  logic                         issue_valid_i,
  input  vseq_pkg::vid_t               issue_id_i,
  input  vseq_pkg::vinsn_op_e          issue_op_i,
  input  vseq_pkg::unit_e              issue_unit_i,
  input  vseq_pkg::vreg_t              issue_vd_i,
  input  vseq_pkg::vreg_t              issue_vs1_i,
  input  vseq_pkg::vreg_t              issue_vs2_i,
  input  vseq_pkg::vid_mask_t          issue_hazard_i,
  input  logic                         idle_i,
  output int                           err_cnt_o,
  output int                           test_cnt_o,
  output int                           pending_o
);

  logic [1:0] id_q [$];
  logic [1:0] unit_q [$];
  logic [3:0] haz_q [$];
  // Request fields carried on to the issue
  vseq_pkg::vinsn_op_e op_q [$];
  vseq_pkg::vreg_t     vd_q [$];
  vseq_pkg::vreg_t     vs1_q [$];
  vseq_pkg::vreg_t     vs2_q [$];

  // Snapshot of a stalled issue
  logic                stalled_q;
  logic                after_rst_q;
  vseq_pkg::vid_t      snap_id;
  vseq_pkg::unit_e     snap_unit;
  vseq_pkg::vid_mask_t snap_haz;

  initial begin
    err_cnt_o  = 0;
    test_cnt_o = 0;
  end

  assign pending_o = id_q.size();

  always @(posedge clk_i) begin
    logic                stall;
    logic                bad;
    logic                bad_regs;
    logic [1:0]          e_id;
    logic [1:0]          e_unit;
    logic [3:0]          e_haz;
    vseq_pkg::vinsn_op_e e_op;
    vseq_pkg::vreg_t     e_vd;
    vseq_pkg::vreg_t     e_vs1;
    vseq_pkg::vreg_t     e_vs2;
    if (!rst_ni) begin
      stalled_q   <= 1'b0;
      after_rst_q <= 1'b1;
    end else begin
      ////////////////////////////////////////
      // Reset state
      ////////////////////////////////////////
      if (after_rst_q) begin
        if (!idle_i || issue_valid_i || !req_ready_i) begin
          $display("[ERROR] %0t ns: wrong state after reset", $time);
          err_cnt_o++;
        end
        after_rst_q <= 1'b0;
      end
      if (exp_valid_i) begin
        id_q.push_back(exp_id_i);
        unit_q.push_back(exp_unit_i);
        haz_q.push_back(exp_hazard_i);
        op_q.push_back(exp_op_i);
        vd_q.push_back(exp_vd_i);
        vs1_q.push_back(exp_vs1_i);
        vs2_q.push_back(exp_vs2_i);
      end
      // Held issue must not move
      if (stalled_q && (!issue_valid_i || issue_id_i != snap_id ||
                        issue_unit_i != snap_unit || issue_hazard_i != snap_haz)) begin
        $display("[ERROR] %0t ns: issue changed while stalled", $time);
        err_cnt_o++;
      end
      stall = issue_valid_i && !unit_ready_i[issue_unit_i];
      if (stall && req_ready_i) begin
        $display("[ERROR] %0t ns: req_ready high during back-pressure", $time);
        err_cnt_o++;
      end
      stalled_q <= stall;
      snap_id   <= issue_id_i;
      snap_unit <= issue_unit_i;
      snap_haz  <= issue_hazard_i;

      ////////////////////////////////////////
      // Consumed issue against expected
      ////////////////////////////////////////
      if (issue_valid_i && unit_ready_i[issue_unit_i]) begin
        test_cnt_o++;
        if (id_q.size() == 0) begin
          $display("Test %0d: issue seen with no request pending", test_cnt_o);
          err_cnt_o++;
        end else begin
          e_id   = id_q.pop_front();
          e_unit = unit_q.pop_front();
          e_haz  = haz_q.pop_front();
          e_op   = op_q.pop_front();
          e_vd   = vd_q.pop_front();
          e_vs1  = vs1_q.pop_front();
          e_vs2  = vs2_q.pop_front();
          bad    = (issue_id_i !== e_id) || (issue_unit_i !== e_unit) ||
                   (issue_hazard_i !== e_haz);
          if (bad) begin
            $display("[ERROR] %0t ns: id %0d unit %0d hazard %b, expected %0d %0d %b",
                     $time, issue_id_i, issue_unit_i, issue_hazard_i, e_id, e_unit, e_haz);
            err_cnt_o++;
          end
          // Opcode and registers pass through from the request
          bad_regs = (issue_op_i !== e_op) || (issue_vd_i !== e_vd) ||
                     (issue_vs1_i !== e_vs1) || (issue_vs2_i !== e_vs2);
          if (bad_regs) begin
            $display("[ERROR] %0t ns: op %0d regs %0d %0d %0d, expected %0d %0d %0d %0d",
                     $time, issue_op_i, issue_vd_i, issue_vs1_i, issue_vs2_i,
                     e_op, e_vd, e_vs1, e_vs2);
            err_cnt_o++;
          end
          // An issued ID is running
          if (idle_i) begin
            $display("[ERROR] %0t ns: idle high with an issue in flight", $time);
            err_cnt_o++;
          end
          $display("Test %0d: id %0d unit %0d hazard %b %s", test_cnt_o, issue_id_i,
                   issue_unit_i, issue_hazard_i, (bad || bad_regs) ? "mismatch" : "ok");
        end
      end
      if (end_check_i && !idle_i) begin
        $display("[ERROR] %0t ns: idle low after all IDs completed", $time);
        err_cnt_o++;
      end
    end
  end

endmodule

`default_nettype wire

// ==== bench/vseq_sva.sv ====
/* Issue handshake assertions */

`timescale 1ns/100ps
`default_nettype none

module vseq_sva (
  input logic                         clk_i,
  input logic                         rst_ni,
  input logic                         req_ready_o,
  input logic [vseq_pkg::NrUnits-1:0] unit_ready_i,
  input logic                         issue_valid_o,
  input vseq_pkg::vid_t               issue_id_o,
  input vseq_pkg::vinsn_op_e          issue_op_o,
  input vseq_pkg::unit_e              issue_unit_o,
  input vseq_pkg::vid_mask_t          issue_hazard_o
);

  logic stalled;

  assign stalled = issue_valid_o && !unit_ready_i[issue_unit_o];

  // Held issue keeps its payload
  stable_while_stalled: assert property (@(posedge clk_i) disable iff (!rst_ni)
    stalled |=> issue_valid_o && $stable(issue_id_o) && $stable(issue_op_o) &&
                $stable(issue_unit_o) && $stable(issue_hazard_o))
    else $error("issue payload changed while stalled");

  // Back-pressure closes the dispatcher port
  no_accept_while_stalled: assert property (@(posedge clk_i) disable iff (!rst_ni)
    stalled |-> !req_ready_o)
    else $error("dispatcher ready during back-pressure");

  // First sampled cycle out of reset
  idle_after_reset: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> !issue_valid_o)
    else $error("issue valid right after reset");

endmodule

bind issue_ctrl vseq_sva i_sva (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .req_ready_o    (req_ready_o),
  .unit_ready_i   (unit_ready_i),
  .issue_valid_o  (issue_valid_o),
  .issue_id_o     (issue_id_o),
  .issue_op_o     (issue_op_o),
  .issue_unit_o   (issue_unit_o),
  .issue_hazard_o (issue_hazard_o)
);

`default_nettype wire

// ==== source/vseq_top.sv ====
/* Vector instruction sequencer */

`timescale 1ns/100ps
`default_nettype none

module vseq_top (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  // Dispatcher
  input  logic                                        req_valid_i,
  input  vseq_pkg::vinsn_op_e                         req_op_i,
  input  vseq_pkg::vreg_t                             req_vd_i,
  input  logic                                        req_use_vd_i,
  input  vseq_pkg::vreg_t                             req_vs1_i,
  input  logic                                        req_use_vs1_i,
  input  vseq_pkg::vreg_t                             req_vs2_i,
  input  logic                                        req_use_vs2_i,
  output logic                                        req_ready_o,
  // Units
  input  logic [vseq_pkg::NrUnits-1:0]                unit_ready_i,
  input  vseq_pkg::vid_mask_t [vseq_pkg::NrUnits-1:0] unit_done_i,
  output logic                                        issue_valid_o,
  output vseq_pkg::vid_t                              issue_id_o,
  output vseq_pkg::vinsn_op_e                         issue_op_o,
  output vseq_pkg::unit_e                             issue_unit_o,
  output vseq_pkg::vreg_t                             issue_vd_o,
  output vseq_pkg::vreg_t                             issue_vs1_o,
  output vseq_pkg::vreg_t                             issue_vs2_o,
  output vseq_pkg::vid_mask_t                         issue_hazard_o,
  output logic                                        idle_o
);

  logic                         accept;
  vseq_pkg::vid_t               accept_id;
  vseq_pkg::unit_e              accept_unit;
  vseq_pkg::vid_t               free_id;
  logic                         full;
  vseq_pkg::vid_mask_t          running;
  vseq_pkg::vid_mask_t          hazard;
  logic [vseq_pkg::NrUnits-1:0] unit_free;

  vid_tracker i_vid_tracker (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .alloc_i      (accept),
    .alloc_id_i   (accept_id),
    .alloc_unit_i (accept_unit),
    .unit_done_i  (unit_done_i),
    .free_id_o    (free_id),
    .full_o       (full),
    .running_o    (running),
    .idle_o       (idle_o)
  );

  vreg_scoreboard i_vreg_scoreboard (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_vd_i      (req_vd_i),
    .req_use_vd_i  (req_use_vd_i),
    .req_vs1_i     (req_vs1_i),
    .req_use_vs1_i (req_use_vs1_i),
    .req_vs2_i     (req_vs2_i),
    .req_use_vs2_i (req_use_vs2_i),
    .accept_i      (accept),
    .accept_id_i   (accept_id),
    .running_i     (running),
    .hazard_o      (hazard)
  );

  unit_occupancy i_unit_occupancy (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .accept_i      (accept),
    .accept_unit_i (accept_unit),
    .unit_done_i   (unit_done_i),
    .unit_free_o   (unit_free)
  );

  issue_ctrl i_issue_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_valid_i    (req_valid_i),
    .req_op_i       (req_op_i),
    .req_vd_i       (req_vd_i),
    .req_vs1_i      (req_vs1_i),
    .req_vs2_i      (req_vs2_i),
    .req_ready_o    (req_ready_o),
    .unit_ready_i   (unit_ready_i),
    .free_id_i      (free_id),
    .full_i         (full),
    .hazard_i       (hazard),
    .unit_free_i    (unit_free),
    .accept_o       (accept),
    .accept_id_o    (accept_id),
    .accept_unit_o  (accept_unit),
    .issue_valid_o  (issue_valid_o),
    .issue_id_o     (issue_id_o),
    .issue_op_o     (issue_op_o),
    .issue_unit_o   (issue_unit_o),
    .issue_vd_o     (issue_vd_o),
    .issue_vs1_o    (issue_vs1_o),
    .issue_vs2_o    (issue_vs2_o),
    .issue_hazard_o (issue_hazard_o)
  );

endmodule

`default_nettype wire

// ==== source/issue_ctrl.sv ====
/* Issue control FSM */

`timescale 1ns/100ps
`default_nettype none

module issue_ctrl (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Dispatcher request
  input  logic                          req_valid_i,
  input  vseq_pkg::vinsn_op_e           req_op_i,
  input  vseq_pkg::vreg_t               req_vd_i,
  input  vseq_pkg::vreg_t               req_vs1_i,
  input  vseq_pkg::vreg_t               req_vs2_i,
  output logic                          req_ready_o,
  // Status from the tracking blocks
  input  logic [vseq_pkg::NrUnits-1:0]  unit_ready_i,
  input  vseq_pkg::vid_t                free_id_i,
  input  logic                          full_i,
  input  vseq_pkg::vid_mask_t           hazard_i,
  input  logic [vseq_pkg::NrUnits-1:0]  unit_free_i,
  // Accept strobe to the tracking blocks
  output logic                          accept_o,
  output vseq_pkg::vid_t                accept_id_o,
  output vseq_pkg::unit_e               accept_unit_o,
  // Issue register
  output logic                          issue_valid_o,
  output vseq_pkg::vid_t                issue_id_o,
  output vseq_pkg::vinsn_op_e           issue_op_o,
  output vseq_pkg::unit_e               issue_unit_o,
  output vseq_pkg::vreg_t               issue_vd_o,
  output vseq_pkg::vreg_t               issue_vs1_o,
  output vseq_pkg::vreg_t               issue_vs2_o,
  output vseq_pkg::vid_mask_t           issue_hazard_o
);

  vseq_pkg::seq_state_e state_d, state_q;
  logic                 can_issue;
  logic                 issue_stall;

  ////////////////////////////////////////
  // Acceptance
  ////////////////////////////////////////

  assign accept_unit_o = vseq_pkg::op_unit(req_op_i);
  assign accept_id_o   = free_id_i;

  // Free ID, room in the unit, and no pending producer for a move
  assign can_issue = !full_i && unit_free_i[accept_unit_o] &&
                     !((req_op_i == vseq_pkg::OP_VMVVX) && (|hazard_i));

  // Held issue not yet taken by its unit
  assign issue_stall = (state_q == vseq_pkg::SEQ_HOLD) && !unit_ready_i[issue_unit_o];

  assign req_ready_o = can_issue && !issue_stall;
  assign accept_o    = req_valid_i && req_ready_o;

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      vseq_pkg::SEQ_IDLE: begin
        if (accept_o) state_d = vseq_pkg::SEQ_HOLD;
      end
      vseq_pkg::SEQ_HOLD: begin
        // Consumed with nothing new behind it
        if (!issue_stall && !accept_o) state_d = vseq_pkg::SEQ_IDLE;
      end
      default: state_d = vseq_pkg::SEQ_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= vseq_pkg::SEQ_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign issue_valid_o = (state_q == vseq_pkg::SEQ_HOLD);

  // Issue payload, loaded only on accept
  always_ff @(posedge clk_i) begin
    if (accept_o) begin
      issue_id_o     <= free_id_i;
      issue_op_o     <= req_op_i;
      issue_unit_o   <= accept_unit_o;
      issue_vd_o     <= req_vd_i;
      issue_vs1_o    <= req_vs1_i;
      issue_vs2_o    <= req_vs2_i;
      issue_hazard_o <= hazard_i;
    end
  end

endmodule

`default_nettype wire

// ==== source/unit_occupancy.sv ====
/* Unit occupancy counters */

`timescale 1ns/100ps
`default_nettype none

module unit_occupancy (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  logic                                        accept_i,
  input  vseq_pkg::unit_e                             accept_unit_i,
  input  vseq_pkg::vid_mask_t [vseq_pkg::NrUnits-1:0] unit_done_i,
  output logic [vseq_pkg::NrUnits-1:0]                unit_free_o
);

  for (genvar u = 0; u < vseq_pkg::NrUnits; u++) begin : gen_unit_cnt
    logic [vseq_pkg::CntWidth-1:0] cnt_q;
    logic                          cnt_up, cnt_down;

    assign cnt_up   = accept_i && (accept_unit_i == vseq_pkg::unit_e'(u));
    // At most one completion per unit per cycle
    assign cnt_down = |unit_done_i[u];

    // Up and down together cancel out
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        cnt_q <= '0;
      end else if (cnt_up && !cnt_down) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (cnt_down && !cnt_up) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end

    // Room left in the unit queue
    assign unit_free_o[u] = cnt_q < vseq_pkg::CntWidth'(vseq_pkg::QueueDepth);
  end

endmodule

`default_nettype wire

// ==== source/vreg_scoreboard.sv ====
/* Vector register scoreboard */

`timescale 1ns/100ps
`default_nettype none

module vreg_scoreboard (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Request under inspection
  input  vseq_pkg::vreg_t     req_vd_i,
  input  logic                req_use_vd_i,
  input  vseq_pkg::vreg_t     req_vs1_i,
  input  logic                req_use_vs1_i,
  input  vseq_pkg::vreg_t     req_vs2_i,
  input  logic                req_use_vs2_i,
  // Accepted request and its ID
  input  logic                accept_i,
  input  vseq_pkg::vid_t      accept_id_i,
  input  vseq_pkg::vid_mask_t running_i,
  output vseq_pkg::vid_mask_t hazard_o
);

  // Last writer and last reader of each register
  vseq_pkg::vid_t                  wr_vid_q [vseq_pkg::NrVRegs];
  vseq_pkg::vid_t                  rd_vid_q [vseq_pkg::NrVRegs];
  logic [vseq_pkg::NrVRegs-1:0]    wr_valid_q, rd_valid_q;
  // Entries whose instruction is still running
  logic [vseq_pkg::NrVRegs-1:0]    wr_live, rd_live;

  always_comb begin
    for (int r = 0; r < vseq_pkg::NrVRegs; r++) begin
      wr_live[r] = wr_valid_q[r] & running_i[wr_vid_q[r]];
      rd_live[r] = rd_valid_q[r] & running_i[rd_vid_q[r]];
    end
  end

  ////////////////////////////////////////
  // Hazard mask
  ////////////////////////////////////////

  always_comb begin
    hazard_o = '0;
    // RAW on the sources
    if (req_use_vs1_i && wr_live[req_vs1_i]) begin
      hazard_o[wr_vid_q[req_vs1_i]] = 1'b1;
    end
    if (req_use_vs2_i && wr_live[req_vs2_i]) begin
      hazard_o[wr_vid_q[req_vs2_i]] = 1'b1;
    end
    if (req_use_vd_i) begin
      // WAR against the last reader
      if (rd_live[req_vd_i]) begin
        hazard_o[rd_vid_q[req_vd_i]] = 1'b1;
      end
      // WAW against the last writer
      if (wr_live[req_vd_i]) begin
        hazard_o[wr_vid_q[req_vd_i]] = 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // List update
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_valid_q <= '0;
      rd_valid_q <= '0;
    end else begin
      // Retired IDs drop out before a reused ID can match again
      wr_valid_q <= wr_live;
      rd_valid_q <= rd_live;
      if (accept_i && req_use_vd_i)  wr_valid_q[req_vd_i]  <= 1'b1;
      if (accept_i && req_use_vs1_i) rd_valid_q[req_vs1_i] <= 1'b1;
      if (accept_i && req_use_vs2_i) rd_valid_q[req_vs2_i] <= 1'b1;
    end
  end

  // IDs only matter while the valid bit is set
  always_ff @(posedge clk_i) begin
    if (accept_i && req_use_vd_i)  wr_vid_q[req_vd_i]  <= accept_id_i;
    if (accept_i && req_use_vs1_i) rd_vid_q[req_vs1_i] <= accept_id_i;
    if (accept_i && req_use_vs2_i) rd_vid_q[req_vs2_i] <= accept_id_i;
  end

endmodule

`default_nettype wire

// ==== source/vid_tracker.sv ====
/* Instruction ID tracker */

`timescale 1ns/100ps
`default_nettype none

module vid_tracker (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  // Allocation of a new ID on accept
  input  logic                                     alloc_i,
  input  vseq_pkg::vid_t                           alloc_id_i,
  input  vseq_pkg::unit_e                          alloc_unit_i,
  // Completion pulses per unit
  input  vseq_pkg::vid_mask_t [vseq_pkg::NrUnits-1:0] unit_done_i,
  output vseq_pkg::vid_t                           free_id_o,
  output logic                                     full_o,
  output vseq_pkg::vid_mask_t                      running_o,
  output logic                                     idle_o
);

  // One running bit per unit per ID
  vseq_pkg::vid_mask_t [vseq_pkg::NrUnits-1:0] table_d, table_q;

  ////////////////////////////////////////
  // Table update
  ////////////////////////////////////////

  always_comb begin
    for (int u = 0; u < vseq_pkg::NrUnits; u++) begin
      // Completions clear first
      table_d[u] = table_q[u] & ~unit_done_i[u];
      // New instruction marked in its unit
      if (alloc_i && (alloc_unit_i == vseq_pkg::unit_e'(u))) begin
        table_d[u][alloc_id_i] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      table_q <= '0;
    end else begin
      table_q <= table_d;
    end
  end

  ////////////////////////////////////////
  // Flags and free ID search
  ////////////////////////////////////////

  always_comb begin
    running_o = '0;
    for (int u = 0; u < vseq_pkg::NrUnits; u++) begin
      running_o |= table_q[u];
    end
  end

  // Scan from the top so the lowest clear ID wins
  always_comb begin
    free_id_o = '0;
    for (int i = vseq_pkg::NrVInsn - 1; i >= 0; i--) begin
      if (!running_o[i]) begin
        free_id_o = vseq_pkg::vid_t'(i);
      end
    end
  end

  assign full_o = &running_o;
  assign idle_o = ~|running_o;

endmodule

`default_nettype wire

// ==== source/vseq_pkg.sv ====
/* Vector sequencer definitions */

`default_nettype none

package vseq_pkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////

  // Instruction IDs in flight
  localparam int unsigned NrVInsn    = 4;
  localparam int unsigned NrVRegs    = 32;
  localparam int unsigned NrUnits    = 3;
  // Per-unit queue capacity and its counter width
  localparam int unsigned QueueDepth = 2;
  localparam int unsigned CntWidth   = 2;

  typedef logic [1:0]         vid_t;
  typedef logic [4:0]         vreg_t;
  typedef logic [NrVInsn-1:0] vid_mask_t;

  ////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////

  typedef enum logic [2:0] {
    OP_VADD   = 3'd0,
    OP_VMUL   = 3'd1,
    OP_VLOAD  = 3'd2,
    OP_VSTORE = 3'd3,
    // Scalar to vector move, no vector source
    OP_VMVVX  = 3'd4
  } vinsn_op_e;

  typedef enum logic [1:0] {
    UNIT_ALU   = 2'd0,
    UNIT_LOAD  = 2'd1,
    UNIT_STORE = 2'd2
  } unit_e;

  typedef enum logic {
    SEQ_IDLE = 1'b0,
    SEQ_HOLD = 1'b1
  } seq_state_e;

  // Target unit of an opcode
  function automatic unit_e op_unit(vinsn_op_e op);
    case (op)
      OP_VLOAD:  op_unit = UNIT_LOAD;
      OP_VSTORE: op_unit = UNIT_STORE;
      // Arithmetic and moves land in the ALU
      default:   op_unit = UNIT_ALU;
    endcase
  endfunction

endpackage

`default_nettype wire
